/* Makefile */
SOURCES := vlog.f $(wildcard source/*.sv) $(wildcard tests/*.sv)

.PHONY: run clean

obj_dir/VarmCoreTb: $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module armCoreTb -f vlog.f

run: obj_dir/VarmCoreTb
	./obj_dir/VarmCoreTb | tee sim.log
	grep -q "^all tests passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* source/armCore.sv */
`timescale 1ns/1ps
`default_nettype none

module armCore (
    input logic clk,
    input logic reset,
    output armPkg::word_t adr,
    output armPkg::word_t writeData,
    input armPkg::word_t readData,
    output logic memWrite
);
    import armPkg::*;

    word_t instr;
    flags_t aluFlags;
    logic irWrite;
    logic adrSrc;
    logic [1:0] resultSrc;
    logic aluSrcA;
    logic [1:0] aluSrcB;
    immSrc_t immSrc;
    logic [1:0] regSrc;
    aluOp_t aluOp;
    logic regW;
    logic memW;
    logic pcS;
    logic nextPc;
    logic [1:0] flagW;
    logic regWrite;
    logic pcWrite;

    controlFsm controlFsm_inst (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .irWrite(irWrite),
        .adrSrc(adrSrc),
        .resultSrc(resultSrc),
        .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB),
        .immSrc(immSrc),
        .regSrc(regSrc),
        .aluOp(aluOp),
        .regW(regW),
        .memW(memW),
        .pcS(pcS),
        .nextPc(nextPc),
        .flagW(flagW)
    );

    condUnit condUnit_inst (
        .clk(clk),
        .reset(reset),
        .cond(instr[31:28]),
        .aluFlags(aluFlags),
        .flagW(flagW),
        .pcS(pcS),
        .nextPc(nextPc),
        .regW(regW),
        .memW(memW),
        .regWrite(regWrite),
        .memWrite(memWrite),
        .pcWrite(pcWrite)
    );

    dataPath dataPath_inst (
        .clk(clk),
        .reset(reset),
        .adr(adr),
        .writeData(writeData),
        .readData(readData),
        .instr(instr),
        .aluFlags(aluFlags),
        .pcWrite(pcWrite),
        .regWrite(regWrite),
        .irWrite(irWrite),
        .adrSrc(adrSrc),
        .resultSrc(resultSrc),
        .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB),
        .immSrc(immSrc),
        .regSrc(regSrc),
        .aluOp(aluOp)
    );

endmodule

`default_nettype wire

/* source/armPkg.sv */
`default_nettype none

package armPkg;

    localparam int wordWidth = 32;
    localparam int regAddrWidth = 4;

    typedef logic [wordWidth-1:0] word_t;       // data, address or instruction
    typedef logic [regAddrWidth-1:0] regAddr_t;
    typedef logic [3:0] flags_t;                // N, Z, C, V
    typedef logic [3:0] cond_t;
    typedef logic [2:0] aluOp_t;
    typedef logic [1:0] immSrc_t;

    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        MEMADR,
        MEMRD,
        MEMWB,
        MEMWR,
        EXECUTER,
        EXECUTEI,
        ALUWB,
        BRANCH
    } ctrlState_t;

    localparam regAddr_t pcReg = 4'd15;
    localparam word_t pcStep = 32'd4;

    // op field, instr[27:26]
    localparam logic [1:0] opDataProc = 2'b00;
    localparam logic [1:0] opMemory = 2'b01;
    localparam logic [1:0] opBranch = 2'b10;

    // cmd field, instr[24:21]
    localparam logic [3:0] cmdAnd = 4'b0000;
    localparam logic [3:0] cmdEor = 4'b0001;
    localparam logic [3:0] cmdSub = 4'b0010;
    localparam logic [3:0] cmdAdd = 4'b0100;
    localparam logic [3:0] cmdOrr = 4'b1100;

    localparam aluOp_t aluAdd = 3'd0;
    localparam aluOp_t aluSub = 3'd1;
    localparam aluOp_t aluAnd = 3'd2;
    localparam aluOp_t aluOrr = 3'd3;
    localparam aluOp_t aluEor = 3'd4;

    localparam immSrc_t immDp8 = 2'b00;     // zero-extended imm8
    localparam immSrc_t immMem12 = 2'b01;   // zero-extended imm12
    localparam immSrc_t immBranch = 2'b10;  // signed imm24, word offset

endpackage

`default_nettype wire

/* source/condUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module condUnit (
    input logic clk,
    input logic reset,
    input armPkg::cond_t cond,
    input armPkg::flags_t aluFlags,
    input logic [1:0] flagW,
    input logic pcS,
    input logic nextPc,
    input logic regW,
    input logic memW,
    output logic regWrite,
    output logic memWrite,
    output logic pcWrite
);
    import armPkg::*;

    logic [1:0] nzFlags;
    logic [1:0] cvFlags;
    flags_t flags;
    logic n, z, c, v;
    logic ge;
    logic condEx;
    logic condReg;   // condition of the instruction in flight

    assign flags = {nzFlags, cvFlags};
    assign {n, z, c, v} = flags;
    assign ge = (n == v);

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            nzFlags <= 2'b00;
        else if (flagW[1] & condReg)
            nzFlags <= aluFlags[3:2];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            cvFlags <= 2'b00;
        else if (flagW[0] & condReg)
            cvFlags <= aluFlags[1:0];
    end

    always_comb begin
        case (cond)
            4'b0000: condEx = z;             // eq
            4'b0001: condEx = ~z;            // ne
            4'b0010: condEx = c;             // cs
            4'b0011: condEx = ~c;            // cc
            4'b0100: condEx = n;             // mi
            4'b0101: condEx = ~n;            // pl
            4'b0110: condEx = v;             // vs
            4'b0111: condEx = ~v;            // vc
            4'b1000: condEx = c & ~z;        // hi
            4'b1001: condEx = ~c | z;        // ls
            4'b1010: condEx = ge;
            4'b1011: condEx = ~ge;           // lt
            4'b1100: condEx = ~z & ge;       // gt
            4'b1101: condEx = z | ~ge;       // le
            4'b1110: condEx = 1'b1;          // al
            default: condEx = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            condReg <= 1'b0;
        else
            condReg <= condEx;
    end

    assign regWrite = regW & condReg;
    assign memWrite = memW & condReg;
    assign pcWrite = nextPc | (pcS & condReg);

endmodule

`default_nettype wire

/* source/controlFsm.sv */
`timescale 1ns/1ps
`default_nettype none

module controlFsm (
    input logic clk,
    input logic reset,
    input armPkg::word_t instr,
    output logic irWrite,
    output logic adrSrc,
    output logic [1:0] resultSrc,
    output logic aluSrcA,
    output logic [1:0] aluSrcB,
    output armPkg::immSrc_t immSrc,
    output logic [1:0] regSrc,
    output armPkg::aluOp_t aluOp,
    output logic regW,
    output logic memW,
    output logic pcS,
    output logic nextPc,
    output logic [1:0] flagW
);
    import armPkg::*;

    ctrlState_t state;
    ctrlState_t nextState;
    logic [1:0] op;
    logic [3:0] cmd;
    logic immBit;
    logic sBit;
    logic loadBit;
    regAddr_t rd;
    logic aluDecode;    // execute states take the ALU op from cmd
    logic branch;

    assign op = instr[27:26];
    assign immBit = instr[25];
    assign cmd = instr[24:21];
    assign sBit = instr[20];
    assign loadBit = instr[20];   // L bit for memory ops
    assign rd = instr[15:12];

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            state <= FETCH;
        else
            state <= nextState;
    end

    always_comb begin
        case (state)
            FETCH: nextState = DECODE;
            DECODE: begin
                case (op)
                    opDataProc: nextState = immBit ? EXECUTEI : EXECUTER;
                    opMemory: nextState = MEMADR;
                    opBranch: nextState = BRANCH;
                    default: nextState = FETCH;   // unsupported op, skip it
                endcase
            end
            MEMADR: nextState = loadBit ? MEMRD : MEMWR;
            MEMRD: nextState = MEMWB;
            EXECUTER: nextState = ALUWB;
            EXECUTEI: nextState = ALUWB;
            default: nextState = FETCH;
        endcase
    end

    // per-state control word
    always_comb begin
        irWrite = 1'b0;
        adrSrc = 1'b0;
        resultSrc = 2'b00;
        aluSrcA = 1'b0;
        aluSrcB = 2'b00;
        nextPc = 1'b0;
        regW = 1'b0;
        memW = 1'b0;
        branch = 1'b0;
        aluDecode = 1'b0;
        case (state)
            FETCH: begin
                irWrite = 1'b1;
                aluSrcA = 1'b1;     // pc + 4
                aluSrcB = 2'b10;
                resultSrc = 2'b10;
                nextPc = 1'b1;
            end
            DECODE: begin
                aluSrcA = 1'b1;     // pc + 8 for R15 reads
                aluSrcB = 2'b10;
                resultSrc = 2'b10;
            end
            MEMADR: aluSrcB = 2'b01;
            MEMRD: adrSrc = 1'b1;
            MEMWB: begin
                resultSrc = 2'b01;
                regW = 1'b1;
            end
            MEMWR: begin
                adrSrc = 1'b1;
                memW = 1'b1;
            end
            EXECUTER: aluDecode = 1'b1;
            EXECUTEI: begin
                aluSrcB = 2'b01;
                aluDecode = 1'b1;
            end
            ALUWB: regW = 1'b1;
            BRANCH: begin
                aluSrcB = 2'b01;    // R15 + offset
                resultSrc = 2'b10;
                branch = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        aluOp = aluAdd;
        flagW = 2'b00;
        if (aluDecode) begin
            case (cmd)
                cmdSub: aluOp = aluSub;
                cmdAnd: aluOp = aluAnd;
                cmdOrr: aluOp = aluOrr;
                cmdEor: aluOp = aluEor;
                default: aluOp = aluAdd;
            endcase
            flagW[1] = sBit;    // N and Z
            flagW[0] = sBit & ((cmd == cmdAdd) | (cmd == cmdSub));
        end
    end

    assign pcS = branch | (regW & (rd == pcReg));

    always_comb begin
        case (op)
            opMemory: immSrc = immMem12;
            opBranch: immSrc = immBranch;
            default: immSrc = immDp8;
        endcase
    end

    assign regSrc[0] = (op == opBranch);    // read R15 as base
    assign regSrc[1] = (op == opMemory);    // Rd is the store data

endmodule

`default_nettype wire

/* source/dataPath.sv */
`timescale 1ns/1ps
`default_nettype none

module dataPath (
    input logic clk,
    input logic reset,
    output armPkg::word_t adr,
    output armPkg::word_t writeData,
    input armPkg::word_t readData,
    output armPkg::word_t instr,
    output armPkg::flags_t aluFlags,
    input logic pcWrite,
    input logic regWrite,
    input logic irWrite,
    input logic adrSrc,
    input logic [1:0] resultSrc,
    input logic aluSrcA,
    input logic [1:0] aluSrcB,
    input armPkg::immSrc_t immSrc,
    input logic [1:0] regSrc,
    input armPkg::aluOp_t aluOp
);
    import armPkg::*;

    word_t pc;
    word_t data;
    word_t regA;
    word_t regB;
    word_t aluOut;
    word_t aluResult;
    word_t result;
    word_t extImm;
    word_t srcA;
    word_t srcB;
    word_t rd1;
    word_t rd2;
    regAddr_t ra1;
    regAddr_t ra2;
    logic [32:0] sum;   // extra bit holds the carry
    logic carry;
    logic overflow;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= '0;
        else if (pcWrite)
            pc <= result;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            instr <= '0;
        else if (irWrite)
            instr <= readData;
    end

    always_ff @(posedge clk) begin
        data <= readData;
        regA <= rd1;
        regB <= rd2;
        aluOut <= aluResult;
    end

    assign adr = adrSrc ? result : pc;
    assign writeData = regB;

    assign ra1 = regSrc[0] ? pcReg : instr[19:16];
    assign ra2 = regSrc[1] ? instr[15:12] : instr[3:0];

    registerFile registerFile_inst (
        .clk(clk),
        .writeEn(regWrite),
        .readAddr1(ra1),
        .readAddr2(ra2),
        .writeAddr(instr[15:12]),
        .writeData(result),
        .pcPlus8(result),
        .readData1(rd1),
        .readData2(rd2)
    );

    always_comb begin
        case (immSrc)
            immDp8: extImm = {24'd0, instr[7:0]};
            immMem12: extImm = {20'd0, instr[11:0]};
            default: extImm = {{6{instr[23]}}, instr[23:0], 2'b00};   // branch offset in words
        endcase
    end

    assign srcA = aluSrcA ? pc : regA;

    always_comb begin
        case (aluSrcB)
            2'b00: srcB = regB;
            2'b01: srcB = extImm;
            default: srcB = pcStep;
        endcase
    end

    always_comb begin
        sum = '0;
        carry = 1'b0;
        overflow = 1'b0;
        case (aluOp)
            aluAdd: begin
                sum = {1'b0, srcA} + {1'b0, srcB};
                aluResult = sum[31:0];
                carry = sum[32];
                overflow = (srcA[31] == srcB[31]) && (aluResult[31] != srcA[31]);
            end
            aluSub: begin
                sum = {1'b0, srcA} + {1'b0, ~srcB} + 33'd1;
                aluResult = sum[31:0];
                carry = sum[32];    // set when no borrow
                overflow = (srcA[31] != srcB[31]) && (aluResult[31] != srcA[31]);
            end
            aluAnd: aluResult = srcA & srcB;
            aluOrr: aluResult = srcA | srcB;
            aluEor: aluResult = srcA ^ srcB;
            default: aluResult = '0;
        endcase
    end

    assign aluFlags = {aluResult[31], (aluResult == '0), carry, overflow};

    always_comb begin
        case (resultSrc)
            2'b00: result = aluOut;
            2'b01: result = data;
            default: result = aluResult;
        endcase
    end

endmodule

`default_nettype wire

/* source/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input logic clk,
    input logic writeEn,
    input armPkg::regAddr_t readAddr1,
    input armPkg::regAddr_t readAddr2,
    input armPkg::regAddr_t writeAddr,
    input armPkg::word_t writeData,
    input armPkg::word_t pcPlus8,
    output armPkg::word_t readData1,
    output armPkg::word_t readData2
);
    import armPkg::*;

    word_t regs [0:14];   // R0..R14, R15 lives in the PC

    always_ff @(posedge clk) begin
        if (writeEn && (writeAddr != pcReg))
            regs[writeAddr] <= writeData;
    end

    assign readData1 = (readAddr1 == pcReg) ? pcPlus8 : regs[readAddr1];
    assign readData2 = (readAddr2 == pcReg) ? pcPlus8 : regs[readAddr2];

endmodule

`default_nettype wire

/* tests/armCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module armCoreTb;
    localparam logic [3:0] cEq = 4'h0, cNe = 4'h1, cCs = 4'h2, cMi = 4'h4;
    localparam logic [3:0] cHi = 4'h8, cLt = 4'hB, cGt = 4'hC, cAl = 4'hE;
    localparam logic [3:0] fAnd = 4'd0, fEor = 4'd1, fSub = 4'd2, fAdd = 4'd4, fOrr = 4'd12;
    localparam logic [31:0] doneAdr = 32'hFC;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic [31:0] adr;
    logic [31:0] writeData;
    logic [31:0] readData;
    logic memWrite;
    logic [31:0] mem [0:255];
    logic [31:0] prog [$];
    logic [31:0] storeAdr [$];
    logic [31:0] storeData [$];
    logic doneSeen = 1'b0;
    logic [31:0] rngState = 32'ha20e7e04;
    int testErrors;
    int passCount = 0;
    int failCount = 0;

    armCore armCore_inst (
        .clk(clk),
        .reset(reset),
        .adr(adr),
        .writeData(writeData),
        .readData(readData),
        .memWrite(memWrite)
    );

    always #4 clk = ~clk;

    assign readData = mem[adr[9:2]];   // combinational read

    always @(posedge clk) begin
        if (memWrite) begin
            mem[adr[9:2]] <= writeData;
            storeAdr.push_back(adr);
            storeData.push_back(writeData);
            if (adr == doneAdr)
                doneSeen = 1'b1;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] dpInstr(input logic [3:0] cond, input logic imm,
        input logic [3:0] cmd, input logic s, input logic [3:0] rn, input logic [3:0] rd,
        input logic [11:0] op2);
        return {cond, 2'b00, imm, cmd, s, rn, rd, op2};
    endfunction

    function automatic logic [31:0] memInstr(input logic [3:0] cond, input logic load,
        input logic [3:0] rn, input logic [3:0] rd, input logic [11:0] offset);
        return {cond, 2'b01, 1'b0, 4'b1100, load, rn, rd, offset};   // pre-index, add offset
    endfunction

    function automatic logic [31:0] brInstr(input logic [3:0] cond, input logic [23:0] offset);
        return {cond, 4'b1010, offset};
    endfunction

    // r0 = 0 from R15 - R15, then rd = imm
    task automatic progStart();
        prog.delete();
        prog.push_back(dpInstr(cAl, 1'b0, fSub, 1'b0, 4'd15, 4'd0, 12'd15));
    endtask

    task automatic progEnd();
        prog.push_back(memInstr(cAl, 1'b0, 4'd0, 4'd0, 12'hFC));
    endtask

    task automatic runProgram();
        int cycles;
        @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < 256; i++)
            mem[i] = (i < prog.size()) ? prog[i] : {24'hF00000, i[7:0]};   // cond never
        storeAdr.delete();
        storeData.delete();
        doneSeen = 1'b0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        cycles = 0;
        while (!doneSeen && cycles < 500) begin
            @(negedge clk);
            cycles++;
        end
        if (!doneSeen) begin
            $display("program never reached its final store within 500 cycles");
            testErrors++;
        end
    endtask

    task automatic checkStore(input logic [31:0] a, input logic [31:0] expected);
        bit found;
        found = 1'b0;
        foreach (storeAdr[i]) begin
            if (storeAdr[i] == a) begin
                found = 1'b1;
                if (storeData[i] !== expected) begin
                    $display("ERROR writeData at adr %h: got %h expected %h",
                        a, storeData[i], expected);
                    testErrors++;
                end
            end
        end
        if (!found) begin
            $display("store to address %h never happened", a);
            testErrors++;
        end
    endtask

    task automatic checkNoStore(input logic [31:0] a);
        foreach (storeAdr[i]) begin
            if (storeAdr[i] == a) begin
                $display("store to address %h happened but its condition failed", a);
                testErrors++;
            end
        end
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            passCount++;
            $display("%s: ok", name);
        end else begin
            failCount++;
            $display("%s: %0d errors", name, testErrors);
        end
    endtask

    task automatic testArithmetic();
        logic [31:0] a, b;
        testErrors = 0;
        rngState = xorshift(rngState);
        a = {24'd0, rngState[7:0]};
        b = {24'd0, rngState[15:8]};
        progStart();
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd0, 4'd1, a[11:0]));
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd0, 4'd2, b[11:0]));
        prog.push_back(dpInstr(cAl, 1'b0, fAdd, 1'b0, 4'd1, 4'd3, 12'd2));
        prog.push_back(dpInstr(cAl, 1'b0, fSub, 1'b0, 4'd1, 4'd4, 12'd2));
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd1, 4'd5, b[11:0]));
        prog.push_back(dpInstr(cAl, 1'b1, fSub, 1'b0, 4'd1, 4'd6, b[11:0]));
        for (int r = 3; r <= 6; r++)
            prog.push_back(memInstr(cAl, 1'b0, 4'd0, r[3:0], 12'h80 + 12'(4 * (r - 3))));
        progEnd();
        runProgram();
        checkStore(32'h80, a + b);
        checkStore(32'h84, a - b);   // wraps when b > a
        checkStore(32'h88, a + b);
        checkStore(32'h8C, a - b);
        finishTest("arithmetic");
    endtask

    task automatic testLogic();
        logic [31:0] a, b;
        testErrors = 0;
        rngState = xorshift(rngState);
        a = {24'd0, rngState[7:0]};
        b = {24'd0, rngState[23:16]};
        progStart();
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd0, 4'd1, a[11:0]));
        prog.push_back(dpInstr(cAl, 1'b1, fAnd, 1'b0, 4'd1, 4'd3, b[11:0]));
        prog.push_back(dpInstr(cAl, 1'b1, fOrr, 1'b0, 4'd1, 4'd4, b[11:0]));
        prog.push_back(dpInstr(cAl, 1'b1, fEor, 1'b0, 4'd1, 4'd5, b[11:0]));
        for (int r = 3; r <= 5; r++)
            prog.push_back(memInstr(cAl, 1'b0, 4'd0, r[3:0], 12'h80 + 12'(4 * (r - 3))));
        progEnd();
        runProgram();
        checkStore(32'h80, a & b);
        checkStore(32'h84, a | b);
        checkStore(32'h88, a ^ b);
        finishTest("logic");
    endtask

    task automatic testMemory();
        logic [31:0] a;
        testErrors = 0;
        rngState = xorshift(rngState);
        a = {24'd0, rngState[7:0]};
        progStart();
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd0, 4'd1, a[11:0]));
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd0, 4'd2, 12'h80));   // base
        prog.push_back(memInstr(cAl, 1'b0, 4'd2, 4'd1, 12'h10));
        prog.push_back(memInstr(cAl, 1'b1, 4'd2, 4'd3, 12'h10));
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd3, 4'd3, 12'd1));
        prog.push_back(memInstr(cAl, 1'b0, 4'd2, 4'd3, 12'h14));
        progEnd();
        runProgram();
        checkStore(32'h90, a);
        checkStore(32'h94, a + 32'd1);
        finishTest("memory");
    endtask

    task automatic testConditions();
        logic [31:0] a, b;
        testErrors = 0;
        rngState = xorshift(rngState);
        a = {24'd0, 1'b1, rngState[6:0]};
        b = {25'd0, rngState[14:8]};   // always below a
        progStart();
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd0, 4'd1, a[11:0]));
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd0, 4'd2, b[11:0]));
        prog.push_back(dpInstr(cAl, 1'b0, fSub, 1'b1, 4'd1, 4'd3, 12'd1));   // Z and C set
        prog.push_back(dpInstr(cEq, 1'b1, fAdd, 1'b0, 4'd0, 4'd4, 12'h55));
        prog.push_back(memInstr(cAl, 1'b0, 4'd0, 4'd4, 12'h80));
        prog.push_back(memInstr(cNe, 1'b0, 4'd0, 4'd1, 12'h84));
        prog.push_back(dpInstr(cAl, 1'b0, fSub, 1'b1, 4'd1, 4'd3, 12'd2));   // a > b
        prog.push_back(memInstr(cNe, 1'b0, 4'd0, 4'd1, 12'h88));
        prog.push_back(memInstr(cCs, 1'b0, 4'd0, 4'd1, 12'h8C));
        prog.push_back(memInstr(cMi, 1'b0, 4'd0, 4'd1, 12'h90));
        prog.push_back(memInstr(cHi, 1'b0, 4'd0, 4'd1, 12'h94));
        prog.push_back(memInstr(cLt, 1'b0, 4'd0, 4'd1, 12'h98));
        prog.push_back(memInstr(cGt, 1'b0, 4'd0, 4'd1, 12'h9C));
        prog.push_back(dpInstr(cAl, 1'b1, fAnd, 1'b1, 4'd1, 4'd3, 12'd0));   // C stays set
        prog.push_back(memInstr(cCs, 1'b0, 4'd0, 4'd1, 12'hA0));
        prog.push_back(memInstr(cEq, 1'b0, 4'd0, 4'd1, 12'hA4));
        progEnd();
        runProgram();
        checkStore(32'h80, 32'h55);
        checkNoStore(32'h84);
        checkStore(32'h88, a);
        checkStore(32'h8C, a);
        checkNoStore(32'h90);
        checkStore(32'h94, a);
        checkNoStore(32'h98);
        checkStore(32'h9C, a);
        checkStore(32'hA0, a);
        checkStore(32'hA4, a);
        finishTest("conditions");
    endtask

    task automatic testBranches();
        logic [31:0] n;
        testErrors = 0;
        rngState = xorshift(rngState);
        n = 32'd1 + (rngState % 32'd15);
        progStart();
        prog.push_back(brInstr(cAl, 24'd0));                                 // skips index 2
        prog.push_back(memInstr(cAl, 1'b0, 4'd0, 4'd0, 12'h80));
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd0, 4'd1, n[11:0]));
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd0, 4'd2, 12'd0));
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd2, 4'd2, 12'd1));  // loop at index 5
        prog.push_back(dpInstr(cAl, 1'b1, fSub, 1'b1, 4'd1, 4'd1, 12'd1));
        prog.push_back(brInstr(cNe, 24'hFFFFFC));                            // back to index 5
        prog.push_back(memInstr(cAl, 1'b0, 4'd0, 4'd2, 12'h84));
        prog.push_back(dpInstr(cAl, 1'b1, fAdd, 1'b0, 4'd15, 4'd3, 12'd0)); // index 9
        prog.push_back(memInstr(cAl, 1'b0, 4'd0, 4'd3, 12'h88));
        progEnd();
        runProgram();
        checkNoStore(32'h80);
        checkStore(32'h84, n);
        checkStore(32'h88, 32'd9 * 32'd4 + 32'd8);
        finishTest("branches");
    endtask

    initial begin
        testArithmetic();
        testLogic();
        testMemory();
        testConditions();
        testBranches();
        $display("%0d tests passed, %0d tests with errors", passCount, failCount);
        if (failCount == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/armCore_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module armCoreAsserts (
    input logic clk,
    input logic reset,
    input armPkg::ctrlState_t state,
    input logic irWrite,
    input logic memW
);
    import armPkg::*;

    logic [2:0] awayCount;   // consecutive cycles outside FETCH

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            awayCount <= 3'd0;
        else if (state == FETCH)
            awayCount <= 3'd0;
        else if (awayCount != 3'd7)
            awayCount <= awayCount + 3'd1;
    end

    resetToFetch: assert property (@(posedge clk) $fell(reset) |-> state == FETCH)
        else $error("state is not FETCH after reset");
    irOnlyFetch: assert property (@(posedge clk) disable iff (reset) irWrite |-> state == FETCH)
        else $error("irWrite outside FETCH");
    memwOnlyWrite: assert property (@(posedge clk) disable iff (reset) memW |-> state == MEMWR)
        else $error("memW outside MEMWR");
    memwSingle: assert property (@(posedge clk) disable iff (reset) memW |=> !memW)
        else $error("memW high for two cycles");
    backToFetch: assert property (@(posedge clk) disable iff (reset)
        state != FETCH |-> awayCount <= 3'd3)
        else $error("FSM stayed away from FETCH too long");

endmodule

bind controlFsm armCoreAsserts asserts_inst (
    .clk(clk),
    .reset(reset),
    .state(state),
    .irWrite(irWrite),
    .memW(memW)
);

`default_nettype wire

/* vlog.f */
source/armPkg.sv
source/registerFile.sv
source/dataPath.sv
source/condUnit.sv
source/controlFsm.sv
source/armCore.sv
tests/armCore_asserts.sv
tests/armCoreTb.sv
